/* verilog/cpu_pkg.sv */
package cpu_pkg;

    // first fetch address and exception entry
    localparam logic [31:0] reset_pc = 32'h1c00_0000;
    localparam logic [31:0] eentry   = 32'h1c00_8000;

    // opcode field inst[31:26]
    localparam logic [5:0] op_jirl = 6'b010011;
    localparam logic [5:0] op_b    = 6'b010100;
    localparam logic [5:0] op_bl   = 6'b010101;

    localparam logic [16:0] inst_syscall_hi = 17'h00056; // low 15 bits are the code
    localparam logic [31:0] inst_ertn       = 32'h0648_3800;

    // one instruction word, read through the format it is decoded with
    typedef union packed {
        struct packed {
            logic [5:0]  opcode;
            logic [15:0] offs_lo;   // offs[15:0]
            logic [9:0]  offs_hi;   // offs[25:16]
        } off26;
        struct packed {
            logic [5:0]  opcode;
            logic [15:0] offs;
            logic [4:0]  rj;
            logic [4:0]  rd;
        } ri16;
    } inst_t;

    // decode to fetch
    typedef struct packed {
        logic        br_taken;
        logic        br_cancel;  // drop the word behind the branch
        logic [31:0] br_target;
    } br_bus_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
    } fs_to_ds_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
    } ds_to_rs_t;

    // retire to fetch and decode
    typedef struct packed {
        logic        flush;
        logic [31:0] flush_pc;
    } flush_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        logic        is_syscall;
    } commit_t;

endpackage

/* verilog/if_stage.sv */
`timescale 1ns/1ns

module if_stage (
    input  logic               clk,
    input  logic               reset,
    input  logic               ds_allowin,
    input  cpu_pkg::br_bus_t   br_bus,
    input  cpu_pkg::flush_t    flush,
    output logic               fs_to_ds_valid,
    output cpu_pkg::fs_to_ds_t fs_to_ds,
    // inst sram, address and data phases split
    output logic               inst_sram_req,
    output logic [31:0]        inst_sram_addr,
    input  logic               inst_sram_addr_ok,
    input  logic               inst_sram_data_ok,
    input  logic [31:0]        inst_sram_rdata
);

    logic        fs_started;
    logic        fs_valid;
    logic [31:0] fs_pc;
    logic        fs_ready_go;
    logic        fs_allowin;
    logic        data_ok_fs;

    logic        fs_inst_valid;
    logic [31:0] fs_inst_r;

    logic        pc_buffer_valid;
    logic [31:0] pc_buffer;
    logic        br_used;
    logic        cancel_r;

    logic        br_new;
    logic        kill;
    logic        addr_hs;
    logic [31:0] seq_pc;
    logic [31:0] nextpc;

    // branch stays on the bus while it waits in decode, redirect only once
    assign br_new = br_bus.br_taken && !br_used;
    assign kill   = flush.flush || (br_bus.br_cancel && !br_used);

    assign seq_pc = fs_pc + 32'd4;
    assign nextpc = flush.flush     ? flush.flush_pc   :
                    pc_buffer_valid ? pc_buffer        :
                    br_new          ? br_bus.br_target :
                                      seq_pc;

    assign addr_hs = inst_sram_req && inst_sram_addr_ok;

    assign data_ok_fs  = inst_sram_data_ok && !cancel_r; // stale return comes first
    assign fs_ready_go = (fs_valid && data_ok_fs) || fs_inst_valid;
    assign fs_allowin  = !fs_valid || kill || (fs_ready_go && ds_allowin);

    assign fs_to_ds_valid = fs_valid && fs_ready_go && !kill;
    assign fs_to_ds.pc    = fs_pc;
    assign fs_to_ds.inst  = fs_inst_valid ? fs_inst_r : inst_sram_rdata;

    assign inst_sram_req  = fs_allowin && fs_started;
    assign inst_sram_addr = nextpc;

    // no request on the first cycle out of reset
    always_ff @(posedge clk) begin
        if (reset) begin
            fs_started <= 1'b0;
        end else begin
            fs_started <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fs_valid <= 1'b0;
            fs_pc    <= cpu_pkg::reset_pc - 32'd4;  // so seq_pc is reset_pc
        end else begin
            if (fs_allowin) begin
                fs_valid <= addr_hs;
            end
            if (addr_hs) begin
                fs_pc <= nextpc;
            end
        end
    end

    // redirect that could not go out yet
    always_ff @(posedge clk) begin
        if (reset) begin
            pc_buffer_valid <= 1'b0;
        end else if (addr_hs) begin
            pc_buffer_valid <= 1'b0;
        end else if (flush.flush || br_new) begin
            pc_buffer_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!addr_hs) begin
            if (flush.flush) begin
                pc_buffer <= flush.flush_pc;
            end else if (br_new) begin
                pc_buffer <= br_bus.br_target;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            br_used <= 1'b0;
        end else if (flush.flush) begin
            br_used <= 1'b0;
        end else if (br_bus.br_taken && ds_allowin) begin
            br_used <= 1'b0;    // branch leaves decode
        end else if (br_bus.br_taken) begin
            br_used <= 1'b1;
        end
    end

    // word kept while decode stalls
    always_ff @(posedge clk) begin
        if (reset) begin
            fs_inst_valid <= 1'b0;
        end else if (kill || fs_allowin) begin
            fs_inst_valid <= 1'b0;
        end else if (fs_valid && data_ok_fs) begin
            fs_inst_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_valid && data_ok_fs) begin
            fs_inst_r <= inst_sram_rdata;
        end
    end

    // killed while its data is still out, so drop the next return
    always_ff @(posedge clk) begin
        if (reset) begin
            cancel_r <= 1'b0;
        end else if (kill && fs_valid && !fs_inst_valid && !data_ok_fs) begin
            cancel_r <= 1'b1;
        end else if (inst_sram_data_ok) begin
            cancel_r <= 1'b0;
        end
    end

endmodule

/* verilog/id_stage.sv */
`timescale 1ns/1ns

module id_stage (
    input  logic               clk,
    input  logic               reset,
    input  logic               fs_to_ds_valid,
    input  cpu_pkg::fs_to_ds_t fs_to_ds,
    output logic               ds_allowin,
    input  logic               rs_allowin,
    input  cpu_pkg::flush_t    flush,
    output cpu_pkg::br_bus_t   br_bus,
    output logic               ds_to_rs_valid,
    output cpu_pkg::ds_to_rs_t ds_to_rs
);

    logic               ds_valid;
    logic               ds_leave;
    cpu_pkg::fs_to_ds_t ds_r;
    cpu_pkg::inst_t     inst;
    logic [31:0]        link_r;     // written by BL only

    logic        is_b;
    logic        is_bl;
    logic        is_jirl;
    logic        is_br;
    logic [31:0] offs26_ext;
    logic [31:0] offs16_ext;
    logic [31:0] jirl_base;
    logic [31:0] seq_pc;

    assign ds_allowin     = !ds_valid || rs_allowin;
    assign ds_to_rs_valid = ds_valid && !flush.flush;
    assign ds_leave       = ds_to_rs_valid && rs_allowin;

    assign ds_to_rs.pc   = ds_r.pc;
    assign ds_to_rs.inst = ds_r.inst;

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (flush.flush) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_to_ds_valid && ds_allowin) begin
            ds_r <= fs_to_ds;
        end
    end

    assign inst   = ds_r.inst;
    assign seq_pc = ds_r.pc + 32'd4;

    assign is_b    = inst.off26.opcode == cpu_pkg::op_b;
    assign is_bl   = inst.off26.opcode == cpu_pkg::op_bl;
    assign is_jirl = inst.ri16.opcode == cpu_pkg::op_jirl;
    assign is_br   = is_b || is_bl || is_jirl;

    // offsets are in words
    assign offs26_ext = {{4{inst.off26.offs_hi[9]}}, inst.off26.offs_hi,
                         inst.off26.offs_lo, 2'b00};
    assign offs16_ext = {{14{inst.ri16.offs[15]}}, inst.ri16.offs, 2'b00};

    // only r1 is tracked, any other rj reads as zero
    assign jirl_base = (inst.ri16.rj == 5'd1) ? link_r : 32'h0;

    assign br_bus.br_taken  = ds_valid && is_br;
    assign br_bus.br_cancel = ds_valid && is_br;  // word after the branch is wrong path
    assign br_bus.br_target = is_jirl ? jirl_base + offs16_ext
                                      : ds_r.pc + offs26_ext;

    always_ff @(posedge clk) begin
        if (reset) begin
            link_r <= 32'h0;
        end else if (ds_leave && is_bl) begin
            link_r <= seq_pc;
        end
    end

endmodule

/* verilog/rt_stage.sv */
`timescale 1ns/1ns

module rt_stage (
    input  logic               clk,
    input  logic               reset,
    input  logic               ds_to_rs_valid,
    input  cpu_pkg::ds_to_rs_t ds_to_rs,
    output logic               rs_allowin,
    output cpu_pkg::flush_t    flush,
    output logic               commit_valid,
    output cpu_pkg::commit_t   commit,
    input  logic               commit_ready
);

    logic               rs_valid;
    cpu_pkg::ds_to_rs_t rs_r;
    logic               rs_is_syscall;
    logic               rs_enter;
    logic               in_syscall;
    logic               in_ertn;
    logic [31:0]        era;        // return address for ertn
    logic               flush_r;
    logic [31:0]        flush_pc_r;

    assign rs_allowin = !rs_valid || commit_ready;
    assign rs_enter   = ds_to_rs_valid && rs_allowin;

    assign in_syscall = ds_to_rs.inst[31:15] == cpu_pkg::inst_syscall_hi;
    assign in_ertn    = ds_to_rs.inst == cpu_pkg::inst_ertn;

    assign commit_valid      = rs_valid;
    assign commit.pc         = rs_r.pc;
    assign commit.inst       = rs_r.inst;
    assign commit.is_syscall = rs_is_syscall;

    assign flush.flush    = flush_r;
    assign flush.flush_pc = flush_pc_r;

    always_ff @(posedge clk) begin
        if (reset) begin
            rs_valid <= 1'b0;
        end else if (rs_allowin) begin
            rs_valid <= ds_to_rs_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (rs_enter) begin
            rs_r          <= ds_to_rs;
            rs_is_syscall <= in_syscall;
        end
    end

    // one cycle pulse on the first cycle the trap or return sits here
    always_ff @(posedge clk) begin
        if (reset) begin
            flush_r <= 1'b0;
        end else begin
            flush_r <= rs_enter && (in_syscall || in_ertn);
        end
    end

    always_ff @(posedge clk) begin
        if (rs_enter) begin
            flush_pc_r <= in_syscall ? cpu_pkg::eentry : era;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            era <= 32'h0;
        end else if (rs_enter && in_syscall) begin
            era <= ds_to_rs.pc + 32'd4;  // resume after the call
        end
    end

endmodule

/* verilog/fetch_top.sv */
`timescale 1ns/1ns

module fetch_top (
    input  logic             clk,
    input  logic             reset,
    output logic             inst_sram_req,
    output logic [31:0]      inst_sram_addr,
    input  logic             inst_sram_addr_ok,
    input  logic             inst_sram_data_ok,
    input  logic [31:0]      inst_sram_rdata,
    output logic             commit_valid,
    output cpu_pkg::commit_t commit,
    input  logic             commit_ready
);

    logic               ds_allowin;
    logic               rs_allowin;
    cpu_pkg::br_bus_t   br_bus;
    cpu_pkg::flush_t    flush;
    logic               fs_to_ds_valid;
    cpu_pkg::fs_to_ds_t fs_to_ds;
    logic               ds_to_rs_valid;
    cpu_pkg::ds_to_rs_t ds_to_rs;

    if_stage u_if_stage (
        .clk               (clk),
        .reset             (reset),
        .ds_allowin        (ds_allowin),
        .br_bus            (br_bus),
        .flush             (flush),
        .fs_to_ds_valid    (fs_to_ds_valid),
        .fs_to_ds          (fs_to_ds),
        .inst_sram_req     (inst_sram_req),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_addr_ok (inst_sram_addr_ok),
        .inst_sram_data_ok (inst_sram_data_ok),
        .inst_sram_rdata   (inst_sram_rdata)
    );

    id_stage u_id_stage (
        .clk            (clk),
        .reset          (reset),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_to_ds       (fs_to_ds),
        .ds_allowin     (ds_allowin),
        .rs_allowin     (rs_allowin),
        .flush          (flush),
        .br_bus         (br_bus),
        .ds_to_rs_valid (ds_to_rs_valid),
        .ds_to_rs       (ds_to_rs)
    );

    rt_stage u_rt_stage (
        .clk            (clk),
        .reset          (reset),
        .ds_to_rs_valid (ds_to_rs_valid),
        .ds_to_rs       (ds_to_rs),
        .rs_allowin     (rs_allowin),
        .flush          (flush),
        .commit_valid   (commit_valid),
        .commit         (commit),
        .commit_ready   (commit_ready)
    );

endmodule

/* testbench/inst_mem_model.sv */
`timescale 1ns/1ns

module inst_mem_model (
    input  logic        clk,
    input  logic        reset,
    input  logic        random_delay,   // low gives accept every cycle, data one cycle later
    input  logic        req,
    input  logic [31:0] addr,
    output logic        addr_ok,
    output logic        data_ok,
    output logic [31:0] rdata
);

    logic [31:0] mem [logic [31:0]];    // sparse image, word aligned keys
    logic [31:0] pending [$];           // accepted addresses, oldest first
    logic [31:0] head_addr;
    int unsigned ret_wait;

    task automatic clear_mem();
        mem.delete();
    endtask

    task automatic load_word(input logic [31:0] a, input logic [31:0] w);
        mem[{a[31:2], 2'b00}] = w;
    endtask

    // unwritten words never decode as a branch or trap
    function automatic logic [31:0] read_word(input logic [31:0] a);
        logic [31:0] key;
        key = {a[31:2], 2'b00};
        if (mem.exists(key)) begin
            return mem[key];
        end
        return {6'b000011, a[27:2] ^ a[31:6]};
    endfunction

    initial begin
        addr_ok = 1'b0;
        data_ok = 1'b0;
        rdata   = 32'h0;
    end

    always @(posedge clk) begin
        if (reset) begin
            pending.delete();
            ret_wait = 0;
            addr_ok <= 1'b0;
            data_ok <= 1'b0;
            rdata   <= 32'h0;
        end else begin
            data_ok <= 1'b0;
            if (pending.size() > 0) begin
                if (ret_wait == 0) begin
                    head_addr = pending.pop_front();
                    data_ok  <= 1'b1;
                    rdata    <= read_word(head_addr);
                    ret_wait = random_delay ? $urandom % 4 : 0;
                end else begin
                    ret_wait = ret_wait - 1;
                end
            end
            if (req && addr_ok) begin
                if (pending.size() == 0) begin
                    ret_wait = random_delay ? $urandom % 4 : 0;
                end
                pending.push_back(addr);   // returns stay in order
            end
            addr_ok <= random_delay ? ($urandom % 3 == 0) : 1'b1;
        end
    end

endmodule

/* testbench/tb_fetch.sv */
`timescale 1ns/1ns

module tb_fetch;

    logic             clk;
    logic             reset;
    logic             mem_random;
    logic             ready_random;
    logic             commit_ready;
    logic             inst_sram_req;
    logic [31:0]      inst_sram_addr;
    logic             inst_sram_addr_ok;
    logic             inst_sram_data_ok;
    logic [31:0]      inst_sram_rdata;
    logic             commit_valid;
    cpu_pkg::commit_t commit;

    int               errors;
    int               checks;
    cpu_pkg::commit_t expected [$];

    fetch_top dut (
        .clk               (clk),
        .reset             (reset),
        .inst_sram_req     (inst_sram_req),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_addr_ok (inst_sram_addr_ok),
        .inst_sram_data_ok (inst_sram_data_ok),
        .inst_sram_rdata   (inst_sram_rdata),
        .commit_valid      (commit_valid),
        .commit            (commit),
        .commit_ready      (commit_ready)
    );

    inst_mem_model imem (
        .clk          (clk),
        .reset        (reset),
        .random_delay (mem_random),
        .req          (inst_sram_req),
        .addr         (inst_sram_addr),
        .addr_ok      (inst_sram_addr_ok),
        .data_ok      (inst_sram_data_ok),
        .rdata        (inst_sram_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // addi.w r0, r0, imm
    function automatic logic [31:0] alu_word(input logic [11:0] imm);
        return {10'b0000001010, imm, 10'h000};
    endfunction

    function automatic logic [31:0] b_word(input logic [5:0] op, input logic [25:0] offs);
        return {op, offs[15:0], offs[25:16]};
    endfunction

    function automatic logic [31:0] jirl_word(input logic [4:0] rj, input logic [15:0] offs);
        return {cpu_pkg::op_jirl, offs, rj, 5'd0};
    endfunction

    task automatic check_value(input string sig, input logic [31:0] got,
                               input logic [31:0] want);
        checks++;
        if (got !== want) begin
            $display("ERR %0t %s got %h expected %h", $time, sig, got, want);
            errors++;
        end
    endtask

    // walk the program image with the architectural rules
    task automatic build_expected(input int count);
        logic [31:0]      pc;
        logic [31:0]      w;
        logic [31:0]      link;
        logic [31:0]      ret;
        logic [31:0]      off26;
        logic [31:0]      off16;
        cpu_pkg::commit_t c;
        expected.delete();
        pc   = cpu_pkg::reset_pc;
        link = 32'h0;
        ret  = 32'h0;
        repeat (count) begin
            w = imem.read_word(pc);
            c.pc         = pc;
            c.inst       = w;
            c.is_syscall = w[31:15] == cpu_pkg::inst_syscall_hi;
            expected.push_back(c);
            off26 = {{4{w[9]}}, w[9:0], w[25:10], 2'b00};
            off16 = {{14{w[25]}}, w[25:10], 2'b00};
            case (w[31:26])
                cpu_pkg::op_b: pc = pc + off26;
                cpu_pkg::op_bl: begin
                    link = pc + 32'd4;
                    pc   = pc + off26;
                end
                cpu_pkg::op_jirl: pc = ((w[9:5] == 5'd1) ? link : 32'h0) + off16;
                default: begin
                    if (c.is_syscall) begin
                        ret = pc + 32'd4;
                        pc  = cpu_pkg::eentry;
                    end else if (w == cpu_pkg::inst_ertn) begin
                        pc = ret;
                    end else begin
                        pc = pc + 32'd4;
                    end
                end
            endcase
        end
    endtask

    task automatic begin_program(input logic rand_mem, input logic rand_ready);
        @(posedge clk);
        reset        <= 1'b1;
        mem_random   <= rand_mem;
        ready_random <= rand_ready;
        commit_ready <= 1'b1;
        imem.clear_mem();
    endtask

    task automatic place_word(input logic [31:0] off, input logic [31:0] w);
        imem.load_word(cpu_pkg::reset_pc + off, w);
    endtask

    // release reset, then compare every commit against the walked trace
    task automatic run_trace(input string name, input int count);
        int               n;
        int               idle;
        int               cyc;
        cpu_pkg::commit_t e;
        build_expected(count);
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        n    = 0;
        idle = 0;
        cyc  = 0;
        while (n < count && idle < 500) begin
            @(posedge clk);
            // req idles one cycle out of reset, then asks for reset_pc
            if (cyc == 0) begin
                check_value("inst_sram_req", {31'b0, inst_sram_req}, 32'h0);
            end else if (cyc == 1) begin
                check_value("inst_sram_req", {31'b0, inst_sram_req}, 32'h1);
                check_value("inst_sram_addr", inst_sram_addr, cpu_pkg::reset_pc);
            end
            cyc++;
            if (commit_valid && commit_ready) begin
                e = expected[n];
                check_value("commit.pc", commit.pc, e.pc);
                check_value("commit.inst", commit.inst, e.inst);
                check_value("commit.is_syscall", {31'b0, commit.is_syscall},
                            {31'b0, e.is_syscall});
                n++;
                idle = 0;
            end else begin
                idle++;
            end
            commit_ready <= ready_random ? ($urandom % 2 == 0) : 1'b1;
        end
        if (n < count) begin
            $display("%s: timed out after %0d of %0d commits", name, n, count);
            errors++;
        end
    endtask

    task automatic straight_line_run();
        begin_program(1'b0, 1'b0);
        for (int i = 0; i < 12; i++) begin
            place_word(32'(i * 4), alu_word(12'(i + 1)));
        end
        run_trace("straight", 10);
    endtask

    task automatic branch_paths(input logic rand_mem, input logic rand_ready);
        begin_program(rand_mem, rand_ready);
        place_word(32'h00, alu_word(12'h001));
        place_word(32'h04, b_word(cpu_pkg::op_b, 26'd3));    // forward to 0x10
        place_word(32'h08, alu_word(12'hbad));
        place_word(32'h0c, alu_word(12'hbad));
        place_word(32'h10, alu_word(12'h002));
        place_word(32'h14, b_word(cpu_pkg::op_b, 26'd4));    // to 0x24
        place_word(32'h18, alu_word(12'h003));
        place_word(32'h1c, b_word(cpu_pkg::op_b, 26'd3));    // to 0x28
        place_word(32'h20, alu_word(12'hbad));
        place_word(32'h24, b_word(cpu_pkg::op_b, -26'd3));   // back to 0x18
        for (int i = 0; i < 4; i++) begin
            place_word(32'h28 + 32'(i * 4), alu_word(12'(i + 4)));
        end
        run_trace("branches", 11);
    endtask

    task automatic call_and_return(input logic rand_mem, input logic rand_ready);
        begin_program(rand_mem, rand_ready);
        place_word(32'h00, alu_word(12'h001));
        place_word(32'h04, b_word(cpu_pkg::op_bl, 26'd4));   // call 0x14
        place_word(32'h08, alu_word(12'h002));
        place_word(32'h0c, jirl_word(5'd0, 16'h0040));       // absolute 0x100
        place_word(32'h10, alu_word(12'hbad));
        place_word(32'h14, alu_word(12'h003));
        place_word(32'h18, jirl_word(5'd1, 16'h0000));       // back through link
        for (int i = 0; i < 4; i++) begin
            imem.load_word(32'h100 + 32'(i * 4), alu_word(12'(i + 4)));
        end
        run_trace("calls", 10);
    endtask

    task automatic trap_and_return(input logic rand_mem, input logic rand_ready);
        begin_program(rand_mem, rand_ready);
        place_word(32'h00, alu_word(12'h001));
        place_word(32'h04, {cpu_pkg::inst_syscall_hi, 15'd5});
        place_word(32'h08, alu_word(12'h002));
        place_word(32'h0c, alu_word(12'h003));
        place_word(32'h10, alu_word(12'h004));
        imem.load_word(cpu_pkg::eentry, alu_word(12'h007));
        imem.load_word(cpu_pkg::eentry + 32'd4, cpu_pkg::inst_ertn);
        imem.load_word(cpu_pkg::eentry + 32'd8, alu_word(12'hbad));
        run_trace("syscall", 7);
    endtask

    initial begin
        errors       = 0;
        checks       = 0;
        reset        = 1'b1;
        mem_random   = 1'b0;
        ready_random = 1'b0;
        commit_ready = 1'b1;
        void'($urandom(16));
        straight_line_run();
        // bit 0 random memory delays, bit 1 random commit_ready
        for (int mode = 0; mode < 8; mode++) begin
            branch_paths(mode[0], mode[1]);
            call_and_return(mode[0], mode[1]);
            trap_and_return(mode[0], mode[1]);
        end
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0 && checks > 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* verilog.f */
verilog/cpu_pkg.sv
verilog/if_stage.sv
verilog/id_stage.sv
verilog/rt_stage.sv
verilog/fetch_top.sv
testbench/inst_mem_model.sv
testbench/tb_fetch.sv

/* Makefile */
FILES = verilog.f

run:
	verilator --binary --timing -j 0 --top-module tb_fetch -f $(FILES) -o tb_fetch
	./obj_dir/tb_fetch | awk '{ print } /ALL CHECKS PASSED/ { ok = 1 } END { exit !ok }'

lint:
	verilator --lint-only -Wall --timing --top-module fetch_top -f $(FILES)

clean:
	rm -rf obj_dir

.PHONY: run lint clean
